// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_alu_ops_generator
FILELIST   = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/alu_ops_pkg.sv
/*
 * ALU ops generator package
 * Configuration word and FSM state encoding of the generator stage
 */

package alu_ops_pkg;

    // ------------------------------------------------
    // Configuration word
    // ------------------------------------------------
    // merge_mask set means forward, clear means drop
    typedef struct packed {
        logic valid;
        logic merge_mask;
    } alu_ops_config_t;

    // ------------------------------------------------
    // Generator FSM
    // ------------------------------------------------
    typedef enum logic [2:0] {
        // One cycle after reset release
        RESET,
        // Waiting for a descriptor
        IDLE,
        // Setup request pulse
        SETUP_REQ,
        // Waiting for the configuration word
        SETUP_WAIT,
        // Draining responses
        BUSY,
        // Output FIFO above threshold
        PAUSE,
        // Job complete, back to IDLE
        DONE
    } alu_ops_gen_state_e;

endpackage

// File: common/engine_pkg.sv
/*
 * Engine package
 * Memory packet and kernel descriptor types shared by the engine blocks
 */

package engine_pkg;

    // ------------------------------------------------
    // Field widths
    // ------------------------------------------------
    // Routing / vertex id
    parameter int META_WIDTH  = 16;
    parameter int FIELD_WIDTH = 32;
    // Responses per job
    parameter int COUNT_WIDTH = 16;

    // ------------------------------------------------
    // Memory packets
    // ------------------------------------------------
    // FIFO data word, 48 bits
    typedef struct packed {
        logic [META_WIDTH-1:0]  meta;
        logic [FIELD_WIDTH-1:0] field;
    } memory_packet_payload_t;

    typedef struct packed {
        logic                   valid;
        memory_packet_payload_t payload;
    } memory_packet_t;

    // ------------------------------------------------
    // Kernel descriptor
    // ------------------------------------------------
    // Starts a job of response_count responses
    typedef struct packed {
        logic                   valid;
        logic [COUNT_WIDTH-1:0] response_count;
    } kernel_descriptor_t;

endpackage

// File: flist.f
common/engine_pkg.sv
common/alu_ops_pkg.sv
hw/sync_fifo.sv
hw/alu_ops_generator/alu_ops_control.sv
hw/alu_ops_generator/alu_ops_merge_stage.sv
hw/alu_ops_generator/alu_ops_generator.sv
tests/tb_clock_gen.sv
tests/tb_alu_ops_generator.sv

// File: hw/alu_ops_generator/alu_ops_control.sv
/*
 * ALU ops generator control
 * Job FSM: descriptor accept, configuration setup, pause on output
 * back-pressure and completion after the descriptor's response count
 */

`timescale 1ns/1ps

module alu_ops_control (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  engine_pkg::kernel_descriptor_t descriptor,
    input  alu_ops_pkg::alu_ops_config_t   config_word,
    input  logic                           consumed,
    input  logic                           out_prog_full,
    output logic                           configure_memory_setup,
    output logic                           params_active,
    output logic                           merge_mask,
    output logic                           pop_enable,
    output logic                           done_out
);
    import engine_pkg::*;
    import alu_ops_pkg::*;

    alu_ops_gen_state_e     state;
    alu_ops_gen_state_e     next_state;
    logic [COUNT_WIDTH-1:0] remaining;
    logic                   done_flag;
    logic                   job_start;
    logic                   config_accept;

    assign job_start     = (state == IDLE) && descriptor.valid;
    assign config_accept = (state == SETUP_WAIT) && config_word.valid;

    // ------------------------------------------------
    // State register and next state
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (descriptor.valid) begin
                    next_state = SETUP_REQ;
                end
            end
            SETUP_REQ: begin
                next_state = SETUP_WAIT;
            end
            SETUP_WAIT: begin
                // Empty job skips straight to completion
                if (config_word.valid) begin
                    next_state = (remaining == '0) ? DONE : BUSY;
                end
            end
            BUSY: begin
                if (remaining == '0) begin
                    next_state = DONE;
                end else if (out_prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                // Pops still in flight can finish the job while paused
                if (remaining == '0) begin
                    next_state = DONE;
                end else if (!out_prog_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // ------------------------------------------------
    // Response count and job parameters
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            remaining <= '0;
        end else if (job_start) begin
            remaining <= descriptor.response_count;
        end else if (consumed) begin
            remaining <= remaining - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            params_active <= 1'b0;
            merge_mask    <= 1'b0;
        end else if (config_accept) begin
            params_active <= 1'b1;
            merge_mask    <= config_word.merge_mask;
        end else if (state == DONE) begin
            params_active <= 1'b0;
        end
    end

    // Done level, held until the next descriptor
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done_flag <= 1'b0;
        end else if (state == DONE) begin
            done_flag <= 1'b1;
        end else if (job_start) begin
            done_flag <= 1'b0;
        end
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    assign configure_memory_setup = (state == SETUP_REQ);
    assign done_out               = done_flag;

    // The merge stage allows one pop at a time and its consumed pulse lands
    // before the next pop, so remaining already counts every issued pop here
    assign pop_enable = (state == BUSY) && (remaining != '0);

    a_consumed_in_job: assert property (@(posedge ap_clk) disable iff (areset_generator)
        consumed |-> (state inside {BUSY, PAUSE}) && (remaining != '0))
        else $error("consumed pulse outside an active job");

endmodule

// File: hw/alu_ops_generator/alu_ops_generator.sv
/*
 * ALU ops generator engine stage
 * Input and output registers around the response and request FIFOs,
 * the job FSM and the merge stage
 */

`timescale 1ns/1ps

module alu_ops_generator #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                           ap_clk,
    input  logic                           areset_generator,
    input  engine_pkg::kernel_descriptor_t descriptor_in,
    input  alu_ops_pkg::alu_ops_config_t   config_in,
    input  engine_pkg::memory_packet_t     response_in,
    output logic                           response_prog_full,
    input  logic                           request_rd_en,
    output engine_pkg::memory_packet_t     request_out,
    output logic                           configure_memory_setup,
    output logic                           done_out
);
    import engine_pkg::*;
    import alu_ops_pkg::*;

    kernel_descriptor_t     descriptor_reg;
    alu_ops_config_t        config_reg;
    memory_packet_t         response_reg;

    logic                   resp_rd_en;
    memory_packet_payload_t resp_dout;
    logic                   resp_valid;
    logic                   resp_empty;

    logic                   req_wr_en;
    memory_packet_payload_t req_din;
    logic                   req_rd_en;
    memory_packet_payload_t req_dout;
    logic                   req_valid;
    logic                   req_empty;
    logic                   req_prog_full;

    logic                   consumed;
    logic                   params_active;
    logic                   merge_mask;
    logic                   pop_enable;

    // ------------------------------------------------
    // Input registers
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_reg.response_count <= descriptor_in.response_count;
        config_reg.merge_mask         <= config_in.merge_mask;
        response_reg.payload          <= response_in.payload;
        if (areset_generator) begin
            descriptor_reg.valid <= 1'b0;
            config_reg.valid     <= 1'b0;
            response_reg.valid   <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
            config_reg.valid     <= config_in.valid;
            response_reg.valid   <= response_in.valid;
        end
    end

    sync_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) response_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (response_reg.valid),
        .din             (response_reg.payload),
        .rd_en           (resp_rd_en),
        .dout            (resp_dout),
        .valid           (resp_valid),
        .empty           (resp_empty),
        .full            (),
        .prog_full       (response_prog_full)
    );

    alu_ops_control control_i (
        .ap_clk                (ap_clk),
        .areset_generator      (areset_generator),
        .descriptor            (descriptor_reg),
        .config_word           (config_reg),
        .consumed              (consumed),
        .out_prog_full         (req_prog_full),
        .configure_memory_setup(configure_memory_setup),
        .params_active         (params_active),
        .merge_mask            (merge_mask),
        .pop_enable            (pop_enable),
        .done_out              (done_out)
    );

    // Forward only while a configuration is live
    alu_ops_merge_stage merge_stage_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .in_empty        (resp_empty),
        .in_valid        (resp_valid),
        .in_dout         (resp_dout),
        .pop_enable      (pop_enable),
        .merge_mask      (params_active & merge_mask),
        .in_rd_en        (resp_rd_en),
        .consumed        (consumed),
        .out_wr_en       (req_wr_en),
        .out_din         (req_din)
    );

    // ------------------------------------------------
    // Request FIFO and output register
    // ------------------------------------------------
    assign req_rd_en = request_rd_en & ~req_empty;

    sync_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) request_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (req_wr_en),
        .din             (req_din),
        .rd_en           (req_rd_en),
        .dout            (req_dout),
        .valid           (req_valid),
        .empty           (req_empty),
        .full            (),
        .prog_full       (req_prog_full)
    );

    always_ff @(posedge ap_clk) begin
        request_out.payload <= req_dout;
        if (areset_generator) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= req_valid;
        end
    end

endmodule

// File: hw/alu_ops_generator/alu_ops_merge_stage.sv
/*
 * ALU ops merge stage
 * Pops responses from the input FIFO and forwards or drops them
 */

`timescale 1ns/1ps

module alu_ops_merge_stage (
    input  logic                               ap_clk,
    input  logic                               areset_generator,
    input  logic                               in_empty,
    input  logic                               in_valid,
    input  engine_pkg::memory_packet_payload_t in_dout,
    input  logic                               pop_enable,
    input  logic                               merge_mask,
    output logic                               in_rd_en,
    output logic                               consumed,
    output logic                               out_wr_en,
    output engine_pkg::memory_packet_payload_t out_din
);

    logic pop_pending;

    // One pop in flight, so at most one pop every two cycles
    assign in_rd_en = ~in_empty & pop_enable & ~pop_pending;
    assign consumed = in_valid;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            pop_pending <= 1'b0;
        end else if (in_valid) begin
            pop_pending <= 1'b0;
        end else if (in_rd_en) begin
            pop_pending <= 1'b1;
        end
    end

    // ------------------------------------------------
    // Forwarding register
    // ------------------------------------------------
    // Dropped responses never raise the write
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_wr_en <= 1'b0;
        end else begin
            out_wr_en <= in_valid & merge_mask;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_valid) begin
            out_din.meta  <= in_dout.meta;
            out_din.field <= in_dout.field;
        end
    end

    a_valid_after_pop: assert property (@(posedge ap_clk) disable iff (areset_generator)
        in_valid |-> $past(in_rd_en))
        else $error("input FIFO data without a matching pop");

endmodule

// File: hw/sync_fifo.sv
/*
 * Synchronous FIFO for memory packet payloads
 * Registered read data with a valid flag, occupancy count and programmable-full level
 */

`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            wr_en,
    input  engine_pkg::memory_packet_payload_t din,
    input  logic                            rd_en,
    output engine_pkg::memory_packet_payload_t dout,
    output logic                            valid,
    output logic                            empty,
    output logic                            full,
    output logic                            prog_full
);
    import engine_pkg::*;

    localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    memory_packet_payload_t mem [DEPTH];
    logic [ADDR_W-1:0]      wr_ptr;
    logic [ADDR_W-1:0]      rd_ptr;
    logic [COUNT_W-1:0]     count;
    logic                   wr_ok;
    logic                   rd_ok;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_ok     = wr_en & ~full;
    assign rd_ok     = rd_en & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == COUNT_W'(DEPTH));
    assign prog_full = (count >= COUNT_W'(PROG_THRESH));

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= rd_ok;
        end
    end

    // Storage and read data register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        wr_en |-> !full)
        else $error("sync_fifo write while full");

    a_no_underflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        rd_en |-> !empty)
        else $error("sync_fifo read while empty");

endmodule

// File: tests/tb_alu_ops_generator.sv
/*
 * ALU ops generator testbench
 * Directed jobs with a reference queue checked against request_out
 */

`timescale 1ns/1ps

module tb_alu_ops_generator;
    import engine_pkg::*;
    import alu_ops_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 600;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
    localparam int WAIT_LIMIT      = 400;
    // Where a sent response is expected to go
    localparam int DEST_EXPECTED   = 0;
    localparam int DEST_HELD       = 1;
    localparam int DEST_NONE       = 2;

    logic               ap_clk;
    logic               areset_generator;
    kernel_descriptor_t descriptor_in;
    alu_ops_config_t    config_in;
    memory_packet_t     response_in;
    logic               response_prog_full;
    logic               request_rd_en;
    memory_packet_t     request_out;
    logic               configure_memory_setup;
    logic               done_out;

    memory_packet_payload_t expected_q[$];
    memory_packet_payload_t held_q[$];
    memory_packet_payload_t monitor_expected;
    int    error_count  = 0;
    int    check_count  = 0;
    int    setup_pulses = 0;
    int    packets_seen = 0;
    int    cycle_count  = 0;
    string test_name    = "none";

    tb_clock_gen #(
        .PERIOD_NS   (100),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator)
    );

    alu_ops_generator #(
        .FIFO_DEPTH (16),
        .PROG_THRESH(8)
    ) dut_i (
        .ap_clk                (ap_clk),
        .areset_generator      (areset_generator),
        .descriptor_in         (descriptor_in),
        .config_in             (config_in),
        .response_in           (response_in),
        .response_prog_full    (response_prog_full),
        .request_rd_en         (request_rd_en),
        .request_out           (request_out),
        .configure_memory_setup(configure_memory_setup),
        .done_out              (done_out)
    );

    task automatic check_equal(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // --------------------------------------------------
    // Monitor and watchdog
    // --------------------------------------------------
    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge ap_clk) begin
        if (!areset_generator) begin
            if (configure_memory_setup) begin
                setup_pulses++;
            end
            if (request_out.valid) begin
                packets_seen++;
                check_count++;
                assert (expected_q.size() != 0) else begin
                    error_count++;
                    $display("Unexpected packet %h on request_out in test %s",
                             request_out.payload, test_name);
                end
                if (expected_q.size() != 0) begin
                    monitor_expected = expected_q.pop_front();
                    check_equal("request_out", monitor_expected, request_out.payload);
                end
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation stopped by the watchdog after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------
    // Drivers and waits
    // --------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ap_clk);
    endtask

    task automatic send_descriptor(input int count);
        @(posedge ap_clk);
        descriptor_in.valid          <= 1'b1;
        descriptor_in.response_count <= COUNT_WIDTH'(count);
        @(posedge ap_clk);
        descriptor_in.valid          <= 1'b0;
    endtask

    task automatic send_config(input logic mask);
        @(posedge ap_clk);
        config_in.valid      <= 1'b1;
        config_in.merge_mask <= mask;
        @(posedge ap_clk);
        config_in.valid      <= 1'b0;
    endtask

    task automatic wait_setup_pulse();
        int waited;
        waited = 0;
        while (!configure_memory_setup && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        check_count++;
        assert (configure_memory_setup) else begin
            error_count++;
            $display("No configure_memory_setup pulse in test %s", test_name);
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done_out && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        check_count++;
        assert (done_out) else begin
            error_count++;
            $display("done_out never rose in test %s", test_name);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        check_count++;
        assert (expected_q.size() == 0) else begin
            error_count++;
            $display("%0d packets never reached request_out in test %s",
                     expected_q.size(), test_name);
        end
    endtask

    // Descriptor, setup pulse, then configuration
    task automatic start_job(input int count, input logic mask);
        send_descriptor(count);
        wait_setup_pulse();
        check_equal("done_out after descriptor", 64'd0, 64'(done_out));
        send_config(mask);
    endtask

    // Holds valid back while the input FIFO is above its threshold
    task automatic send_responses(input int n, input int dest);
        memory_packet_payload_t pkt;
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge ap_clk);
            if (response_prog_full) begin
                @(posedge ap_clk);
                response_in.valid <= 1'b0;
            end else begin
                pkt.meta  = META_WIDTH'($urandom());
                pkt.field = FIELD_WIDTH'($urandom());
                if (dest == DEST_EXPECTED) begin
                    expected_q.push_back(pkt);
                end else if (dest == DEST_HELD) begin
                    held_q.push_back(pkt);
                end
                @(posedge ap_clk);
                response_in.valid   <= 1'b1;
                response_in.payload <= pkt;
                sent++;
            end
        end
        @(posedge ap_clk);
        response_in.valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_outputs();
        test_name = "reset_outputs";
        @(negedge ap_clk);
        check_equal("request_out.valid", 64'd0, 64'(request_out.valid));
        check_equal("configure_memory_setup", 64'd0, 64'(configure_memory_setup));
        check_equal("done_out", 64'd0, 64'(done_out));
    endtask

    task automatic test_setup_before_config();
        int pulses_before;
        int seen_before;
        test_name     = "setup_before_config";
        pulses_before = setup_pulses;
        seen_before   = packets_seen;
        send_descriptor(8);
        wait_setup_pulse();
        // Eight held responses reach the input FIFO threshold
        send_responses(8, DEST_EXPECTED);
        wait_cycles(20);
        @(negedge ap_clk);
        check_equal("setup pulses", 64'd1, 64'(setup_pulses - pulses_before));
        check_equal("packets before config", 64'd0, 64'(packets_seen - seen_before));
        check_equal("response_prog_full while waiting", 64'd1, 64'(response_prog_full));
        send_config(1'b1);
        wait_done();
        wait_drained();
        check_equal("setup pulses per job", 64'd1, 64'(setup_pulses - pulses_before));
        check_equal("response_prog_full after drain", 64'd0, 64'(response_prog_full));
    endtask

    task automatic test_forward_job();
        int seen_before;
        test_name   = "forward_job";
        seen_before = packets_seen;
        start_job(10, 1'b1);
        send_responses(10, DEST_EXPECTED);
        wait_done();
        wait_drained();
        wait_cycles(10);
        check_equal("packets forwarded", 64'd10, 64'(packets_seen - seen_before));
    endtask

    task automatic test_drop_job();
        int seen_before;
        test_name   = "drop_job";
        seen_before = packets_seen;
        start_job(6, 1'b0);
        send_responses(6, DEST_NONE);
        wait_done();
        wait_cycles(10);
        @(negedge ap_clk);
        check_equal("packets forwarded", 64'd0, 64'(packets_seen - seen_before));
        check_equal("done_out held", 64'd1, 64'(done_out));
        // Empty job clears done, then completes straight from configuration
        start_job(0, 1'b1);
        wait_done();
    endtask

    task automatic test_back_pressure();
        int seen_before;
        test_name   = "back_pressure";
        seen_before = packets_seen;
        @(posedge ap_clk);
        request_rd_en <= 1'b0;
        start_job(14, 1'b1);
        send_responses(14, DEST_EXPECTED);
        wait_cycles(40);
        @(negedge ap_clk);
        check_equal("packets while stalled", 64'd0, 64'(packets_seen - seen_before));
        check_equal("done_out while stalled", 64'd0, 64'(done_out));
        @(posedge ap_clk);
        request_rd_en <= 1'b1;
        wait_done();
        wait_drained();
        wait_cycles(10);
        check_equal("packets forwarded", 64'd14, 64'(packets_seen - seen_before));
    endtask

    task automatic test_back_to_back();
        int seen_before;
        test_name   = "back_to_back";
        seen_before = packets_seen;
        start_job(5, 1'b1);
        // Second job's responses wait behind the first job's count
        send_responses(5, DEST_EXPECTED);
        send_responses(4, DEST_HELD);
        wait_done();
        wait_drained();
        wait_cycles(20);
        check_equal("first job packets", 64'd5, 64'(packets_seen - seen_before));
        while (held_q.size() != 0) begin
            expected_q.push_back(held_q.pop_front());
        end
        start_job(4, 1'b1);
        wait_done();
        wait_drained();
        wait_cycles(10);
        check_equal("both jobs packets", 64'd9, 64'(packets_seen - seen_before));
    endtask

    initial begin
        void'($urandom(15));
        descriptor_in = '0;
        config_in     = '0;
        response_in   = '0;
        request_rd_en = 1'b0;
        @(negedge areset_generator);
        @(posedge ap_clk);
        request_rd_en <= 1'b1;

        test_reset_outputs();
        test_setup_before_config();
        test_forward_job();
        test_drop_job();
        test_back_pressure();
        test_back_to_back();

        wait_cycles(5);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic ap_clk,
    output logic areset_generator
);

    initial begin
        ap_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) ap_clk = ~ap_clk;
    end

    // Synchronous release after the reset cycles
    initial begin
        areset_generator = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_generator <= 1'b0;
    end

endmodule
